/* hdl/board_macros.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board test build constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef BOARD_MACROS_SVH
`define BOARD_MACROS_SVH

// Frame buffer address width, 64 bytes
`define BUF_ADDR_BITS 6

// Longest frame accepted for echo, in bytes
`define MAX_FRAME 64

// Idle cycles from the last received byte to the first echoed byte
`define ECHO_GAP 12

// PHY reset hold time in tx_clk cycles
`define PHY_RESET_CYCLES 100

`endif

/* hdl/gmii_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// GMII link types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package gmii_pkg;

	// Transmit byte lane
	typedef struct packed {
		logic [7:0] data;
		logic       en;
		logic       er;
	} gmii_tx_t;

	// Receive byte lane
	typedef struct packed {
		logic [7:0] data;
		logic       dv;
		logic       er;
	} gmii_rx_t;

	// RGMII pin group, one nibble plus control per half cycle
	typedef struct packed {
		logic [3:0] data;
		logic       ctl;
	} rgmii_lane_t;

endpackage

/* hdl/board_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board status types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package board_pkg;

	// Frame counters shown on the LEDs
	// Both wrap at 16
	typedef struct packed {
		logic [3:0] echoed;
		logic [3:0] dropped;
	} frame_stats_t;

	// Why a received frame was not echoed
	// none marks a frame ignored without counting
	typedef enum logic [1:0] {
		none,
		rx_error,
		too_long,
		busy
	} drop_reason_t;

endpackage

/* hdl/rgmii_ddr_io.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RGMII DDR converter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module rgmii_ddr_io (
	input  logic                  tx_clk,
	input  logic                  arst_n,
	input  gmii_pkg::gmii_tx_t    tx_byte,
	output gmii_pkg::gmii_rx_t    rx_byte,
	output gmii_pkg::rgmii_lane_t rgmii_tx,
	output logic                  rgmii_tx_clk,
	input  gmii_pkg::rgmii_lane_t rgmii_rx
);
	import gmii_pkg::*;

	// Transmit byte held for one full cycle
	gmii_tx_t    tx_q;
	// Low half of the receive lane, taken at the falling edge
	rgmii_lane_t rx_lo_q;
	// Nibble pair realigned to the rising edge
	rgmii_lane_t pair_lo;
	rgmii_lane_t pair_hi;

	// Transmit register
	// Byte from frame_echo goes out on the pins in the next cycle
	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			tx_q <= '0;
		end else begin
			tx_q <= tx_byte;
		end
	end

	// Behavioral ODDR
	// High phase carries the low nibble and en
	// Low phase carries the high nibble and en xor er
	always_comb begin
		if (tx_clk) begin
			rgmii_tx.data = tx_q.data[3:0];
			rgmii_tx.ctl  = tx_q.en;
		end else begin
			rgmii_tx.data = tx_q.data[7:4];
			rgmii_tx.ctl  = tx_q.en ^ tx_q.er;
		end
	end

	// Clock forwarded in phase
	assign rgmii_tx_clk = tx_clk;

	// Low nibble and dv are stable through the high phase
	// so the falling edge closes that half
	always_ff @(negedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			rx_lo_q <= '0;
		end else begin
			rx_lo_q <= rgmii_rx;
		end
	end

	// High nibble closes at the next rising edge
	// Low half is moved into the same edge here
	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			pair_lo <= '0;
			pair_hi <= '0;
			rx_byte <= '0;
		end else begin
			pair_lo <= rx_lo_q;
			pair_hi <= rgmii_rx;
			// Rebuild the byte and decode er from the two ctl samples
			rx_byte <= '{data: {pair_hi.data, pair_lo.data},
				dv: pair_lo.ctl,
				er: pair_lo.ctl ^ pair_hi.ctl};
		end
	end

	// Rising edge still samples the low phase of the byte in tx_q
	// A high ctl there with en low would be er without en on the wire
	a_no_er_without_en: assert property (@(posedge tx_clk) disable iff (!arst_n)
		rgmii_tx.ctl |-> tx_q.en);

endmodule

/* hdl/phy_reset_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PHY reset sequencer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "board_macros.svh"

module phy_reset_gen (
	input  logic tx_clk,
	input  logic arst_n,
	output logic phy_rstn
);
	localparam int cnt_bits = $clog2(`PHY_RESET_CYCLES + 1);

	// Edges seen since board reset was released
	logic [cnt_bits-1:0] cnt;

	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt      <= '0;
			phy_rstn <= 1'b0;
		end else begin
			// Saturates at the hold length
			if (cnt != cnt_bits'(`PHY_RESET_CYCLES)) begin
				cnt <= cnt + cnt_bits'(1);
			end
			// Old count is one short on the final edge of the hold
			if (cnt == cnt_bits'(`PHY_RESET_CYCLES - 1)) begin
				phy_rstn <= 1'b1;
			end
		end
	end

	// PHY stays out of reset until the next board reset
	a_phy_rstn_sticky: assert property (@(posedge tx_clk) disable iff (!arst_n)
		phy_rstn |=> phy_rstn);

endmodule

/* hdl/frame_echo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Store-and-forward frame echo
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "board_macros.svh"

module frame_echo (
	input  logic                    tx_clk,
	input  logic                    arst_n,
	input  logic                    enable,
	input  gmii_pkg::gmii_rx_t      rx_byte,
	output gmii_pkg::gmii_tx_t      tx_byte,
	output board_pkg::frame_stats_t stats
);
	import board_pkg::*;

	localparam int len_bits = $clog2(`MAX_FRAME + 1);
	localparam int gap_bits = $clog2(`ECHO_GAP);
	// End of frame is seen one cycle after the last byte
	// and the gap state starts one cycle after that
	localparam int gap_load = `ECHO_GAP - 3;

	typedef enum logic [1:0] {rx_idle, rx_capture, rx_discard} rx_state_t;
	typedef enum logic [1:0] {tx_idle, tx_gap, tx_send} tx_state_t;

	rx_state_t           rx_state;
	tx_state_t           tx_state;
	drop_reason_t        reason;
	logic [7:0]          buf_mem [0:(1 << `BUF_ADDR_BITS) - 1];
	logic [len_bits-1:0] wr_cnt;
	logic [len_bits-1:0] frame_len;
	logic [len_bits-1:0] rd_cnt;
	logic [gap_bits-1:0] gap_cnt;
	logic                start_ok;
	logic                buf_wr;
	logic                frame_commit;
	logic                frame_drop;

	// New frame may be captured only when enabled and nothing is pending
	assign start_ok = enable && (tx_state == tx_idle);

	// Clean byte of an accepted frame, still inside the buffer
	assign buf_wr = rx_byte.dv && !rx_byte.er &&
		((rx_state == rx_idle && start_ok) ||
		(rx_state == rx_capture && wr_cnt != len_bits'(`MAX_FRAME)));

	// Good frame ends
	assign frame_commit = (rx_state == rx_capture) && !rx_byte.dv;
	// Bad frame ends, ignored frames leave no count
	assign frame_drop = (rx_state == rx_discard) && !rx_byte.dv && (reason != none);

	// Frame buffer
	always_ff @(posedge tx_clk) begin
		if (buf_wr) begin
			buf_mem[wr_cnt[`BUF_ADDR_BITS-1:0]] <= rx_byte.data;
		end
	end

	// Receive FSM
	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			rx_state  <= rx_idle;
			reason    <= none;
			wr_cnt    <= '0;
			frame_len <= '0;
		end else begin
			case (rx_state)
				rx_idle: begin
					if (rx_byte.dv) begin
						if (!enable) begin
							// PHY still held in reset
							rx_state <= rx_discard;
							reason   <= none;
						end else if (!start_ok) begin
							rx_state <= rx_discard;
							reason   <= busy;
						end else if (rx_byte.er) begin
							rx_state <= rx_discard;
							reason   <= rx_error;
						end else begin
							// First byte written at address 0
							rx_state <= rx_capture;
							wr_cnt   <= len_bits'(1);
						end
					end
				end
				rx_capture: begin
					if (!rx_byte.dv) begin
						frame_len <= wr_cnt;
						wr_cnt    <= '0;
						rx_state  <= rx_idle;
					end else if (rx_byte.er) begin
						rx_state <= rx_discard;
						reason   <= rx_error;
						wr_cnt   <= '0;
					end else if (wr_cnt == len_bits'(`MAX_FRAME)) begin
						// One byte past the limit, drop the rest
						rx_state <= rx_discard;
						reason   <= too_long;
						wr_cnt   <= '0;
					end else begin
						wr_cnt <= wr_cnt + len_bits'(1);
					end
				end
				default: begin
					if (!rx_byte.dv) begin
						rx_state <= rx_idle;
						reason   <= none;
					end
				end
			endcase
		end
	end

	// Transmit FSM and counters
	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			tx_state <= tx_idle;
			gap_cnt  <= '0;
			rd_cnt   <= '0;
			stats    <= '0;
		end else begin
			if (frame_drop) begin
				stats.dropped <= stats.dropped + 4'd1;
			end
			case (tx_state)
				tx_idle: begin
					if (frame_commit) begin
						tx_state <= tx_gap;
						gap_cnt  <= gap_bits'(gap_load);
					end
				end
				tx_gap: begin
					if (gap_cnt == '0) begin
						tx_state <= tx_send;
						rd_cnt   <= '0;
					end else begin
						gap_cnt <= gap_cnt - gap_bits'(1);
					end
				end
				default: begin
					// Count the echo once its last byte is out
					if (rd_cnt == frame_len - len_bits'(1)) begin
						tx_state     <= tx_idle;
						stats.echoed <= stats.echoed + 4'd1;
					end else begin
						rd_cnt <= rd_cnt + len_bits'(1);
					end
				end
			endcase
		end
	end

	// Buffer read straight onto the transmit lane
	assign tx_byte = '{data: buf_mem[rd_cnt[`BUF_ADDR_BITS-1:0]],
		en: (tx_state == tx_send),
		er: 1'b0};

	// en only while reading inside the committed frame
	a_tx_en_in_send: assert property (@(posedge tx_clk) disable iff (!arst_n)
		tx_byte.en |-> (rd_cnt < frame_len));

	// Committed length fits the buffer
	a_frame_len_range: assert property (@(posedge tx_clk) disable iff (!arst_n)
		frame_commit |=> (frame_len != '0) && (frame_len <= len_bits'(`MAX_FRAME)));

endmodule

/* hdl/board_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Ethernet test board top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module board_top (
	input  logic                  tx_clk,
	input  logic                  arst_n,
	// RGMII transmit pins
	output gmii_pkg::rgmii_lane_t rgmii_tx,
	output logic                  rgmii_tx_clk,
	// RGMII receive pins, sampled on tx_clk
	input  gmii_pkg::rgmii_lane_t rgmii_rx,
	// Reset to the PHY
	output logic                  phy_rstn,
	// Dropped count high, echoed count low
	output logic [7:0]            leds
);
	import gmii_pkg::*;
	import board_pkg::*;

	// GMII bytes between converter and echo block
	gmii_rx_t     rx_byte;
	gmii_tx_t     tx_byte;
	// Frame counters
	frame_stats_t stats;

	// DDR conversion
	rgmii_ddr_io u_rgmii_ddr_io (
		.tx_clk       (tx_clk),
		.arst_n       (arst_n),
		.tx_byte      (tx_byte),
		.rx_byte      (rx_byte),
		.rgmii_tx     (rgmii_tx),
		.rgmii_tx_clk (rgmii_tx_clk),
		.rgmii_rx     (rgmii_rx)
	);

	// PHY reset hold
	phy_reset_gen u_phy_reset_gen (
		.tx_clk   (tx_clk),
		.arst_n   (arst_n),
		.phy_rstn (phy_rstn)
	);

	// Echo runs only once the PHY is out of reset
	frame_echo u_frame_echo (
		.tx_clk  (tx_clk),
		.arst_n  (arst_n),
		.enable  (phy_rstn),
		.rx_byte (rx_byte),
		.tx_byte (tx_byte),
		.stats   (stats)
	);

	// Counters onto the LED bus
	assign leds = {stats.dropped, stats.echoed};

endmodule

/* bench/echo_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Echo checker and model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "board_macros.svh"

module echo_checker (
	input  logic                  tx_clk,
	input  logic                  arst_n,
	input  gmii_pkg::rgmii_lane_t rgmii_rx,
	input  gmii_pkg::rgmii_lane_t rgmii_tx,
	input  logic                  rgmii_tx_clk,
	input  logic                  phy_rstn,
	input  logic [7:0]            leds,
	output int                    errors,
	output int                    checks,
	output int                    pending
);
	import gmii_pkg::*;

	// Half-cycle samples of both lanes
	rgmii_lane_t rx_lo, rx_hi, tx_lo, tx_hi;
	logic [7:0]  rx_cur[$];
	logic [7:0]  tx_cur[$];
	// Expected echoes, bytes flattened
	logic [7:0]  exp_bytes[$];
	int          exp_len[$];
	int          exp_start[$];
	logic        in_rx, in_tx, rx_err, rx_phy, rx_busy;
	// Model counters, wrap at 16 like the LEDs
	logic [3:0]  n_echoed, n_dropped;
	int          cyc, edges, tx_first, drop_wait;

	task automatic compare_value(input string name, input int exp, input int got);
		checks++;
		if (exp != got) begin
			errors++;
			$display("FAIL time=%0t signal=%s expected=%0h got=%0h", $time, name, exp, got);
		end
	endtask

	// Receive lane into frames, then decide echo or drop
	task automatic decode_rx_frame();
		int i;
		if (rx_lo.ctl) begin
			if (!in_rx) begin
				in_rx   = 1'b1;
				rx_err  = 1'b0;
				rx_phy  = phy_rstn;
				// Any echo still owed means the echo block is busy
				rx_busy = (exp_len.size() != 0);
				rx_cur.delete();
			end
			rx_err = rx_err | (rx_lo.ctl ^ rx_hi.ctl);
			rx_cur.push_back({rx_hi.data, rx_lo.data});
		end else if (in_rx) begin
			in_rx = 1'b0;
			// Dropped count looked at after every frame, counted or not
			drop_wait = 4;
			// Frames starting under PHY reset leave no trace
			if (rx_phy) begin
				if (rx_err || rx_cur.size() > `MAX_FRAME || rx_busy) begin
					n_dropped++;
				end else begin
					for (i = 0; i < rx_cur.size(); i++) begin
						exp_bytes.push_back(rx_cur[i]);
					end
					exp_len.push_back(rx_cur.size());
					// Last pair was in cyc-1, echo lands 3+gap cycles later
					exp_start.push_back(cyc + 2 + `ECHO_GAP);
				end
			end
		end
	endtask

	// Transmit lane into frames, compared against the owed echoes
	task automatic track_echo();
		int len;
		int i;
		logic [7:0] exp_b;
		if (tx_lo.ctl) begin
			if (!in_tx) begin
				in_tx    = 1'b1;
				tx_first = cyc;
				tx_cur.delete();
			end
			compare_value("rgmii_tx er", 0, tx_lo.ctl ^ tx_hi.ctl);
			tx_cur.push_back({tx_hi.data, tx_lo.data});
		end else if (in_tx) begin
			in_tx = 1'b0;
			if (exp_len.size() == 0) begin
				errors++;
				$display("Echo of %0d bytes came out at %0t with no frame owed",
					tx_cur.size(), $time);
			end else begin
				len = exp_len.pop_front();
				compare_value("echo start cycle", exp_start.pop_front(), tx_first);
				compare_value("echo length", len, tx_cur.size());
				for (i = 0; i < len; i++) begin
					exp_b = exp_bytes.pop_front();
					if (i < tx_cur.size()) begin
						compare_value("rgmii_tx data", exp_b, tx_cur[i]);
					end
				end
				// Echo count already moved with the last byte
				n_echoed++;
				compare_value("leds echoed", n_echoed, leds[3:0]);
			end
		end
	endtask

	// Dropped count settles a few cycles after the frame ends
	task automatic check_drop_count();
		if (drop_wait != 0) begin
			drop_wait--;
			if (drop_wait == 0) begin
				compare_value("leds dropped", n_dropped, leds[7:4]);
			end
		end
	endtask

	initial begin
		errors    = 0;
		checks    = 0;
		pending   = 0;
		cyc       = 0;
		edges     = 0;
		in_rx     = 1'b0;
		in_tx     = 1'b0;
		n_echoed  = '0;
		n_dropped = '0;
		drop_wait = 0;
		forever begin
			@(posedge tx_clk);
			cyc++;
			// Edges with reset released, the release edge itself excluded
			if (arst_n) begin
				edges++;
			end
			#10;
			rx_lo = rgmii_rx;
			tx_lo = rgmii_tx;
			// Forwarded clock follows tx_clk in phase
			compare_value("rgmii_tx_clk", 1, rgmii_tx_clk);
			@(negedge tx_clk);
			#10;
			rx_hi = rgmii_rx;
			tx_hi = rgmii_tx;
			compare_value("rgmii_tx_clk", 0, rgmii_tx_clk);
			if (!arst_n) begin
				compare_value("leds", 0, leds);
				compare_value("phy_rstn", 0, phy_rstn);
				compare_value("rgmii_tx ctl", 0, tx_lo.ctl | tx_hi.ctl);
			end else begin
				compare_value("phy_rstn", edges >= `PHY_RESET_CYCLES, phy_rstn);
				check_drop_count();
				decode_rx_frame();
				track_echo();
			end
			pending = exp_len.size();
		end
	end

endmodule

/* bench/board_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board echo testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "board_macros.svh"

module board_tb;
	import gmii_pkg::*;

	// Idle time that lets any echo finish before the next frame
	localparam int idle_gap = `MAX_FRAME + `ECHO_GAP + 8;

	logic        tx_clk;
	logic        arst_n;
	rgmii_lane_t rgmii_rx;
	rgmii_lane_t rgmii_tx;
	logic        rgmii_tx_clk;
	logic        phy_rstn;
	logic [7:0]  leds;
	int          errors, checks, pending;
	int          cycles, limit, len;
	int          tests_run, tests_failed, errors_at_start;

	board_top u_board_top (
		.tx_clk       (tx_clk),
		.arst_n       (arst_n),
		.rgmii_tx     (rgmii_tx),
		.rgmii_tx_clk (rgmii_tx_clk),
		.rgmii_rx     (rgmii_rx),
		.phy_rstn     (phy_rstn),
		.leds         (leds)
	);

	echo_checker u_echo_checker (
		.tx_clk       (tx_clk),
		.arst_n       (arst_n),
		.rgmii_rx     (rgmii_rx),
		.rgmii_tx     (rgmii_tx),
		.rgmii_tx_clk (rgmii_tx_clk),
		.phy_rstn     (phy_rstn),
		.leds         (leds),
		.errors       (errors),
		.checks       (checks),
		.pending      (pending)
	);

	initial begin
		tx_clk = 1'b0;
		forever #20 tx_clk = ~tx_clk;
	end

	// Watchdog, limit grows with every frame sent
	initial begin
		while (cycles <= limit) begin
			@(posedge tx_clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, echoes still owed %0d", cycles, pending);
		$display("Simulation finished: FAIL");
		$finish;
	end

	function automatic int rand_range(input int lo, input int hi);
		logic [31:0] r;
		r = $urandom;
		return lo + int'(r % (hi - lo + 1));
	endfunction

	// One frame on the RGMII receive pins, er forced on byte err_at
	task automatic send_frame(input int n, input int err_at, input int gap);
		int i;
		logic [31:0] r;
		limit += n + gap + `ECHO_GAP + 10;
		for (i = 0; i < n; i++) begin
			r = $urandom;
			@(posedge tx_clk);
			#2;
			rgmii_rx = {r[3:0], 1'b1};
			@(negedge tx_clk);
			#2;
			// Falling half carries dv xor er
			rgmii_rx = {r[7:4], (i != err_at)};
		end
		repeat (gap) begin
			@(posedge tx_clk);
			#2;
			rgmii_rx = '0;
		end
	endtask

	task automatic finish_test(input string name);
		while (pending != 0) begin
			@(posedge tx_clk);
		end
		tests_run++;
		if (errors != errors_at_start) begin
			tests_failed++;
			$display("Test %s: failed, %0d errors", name, errors - errors_at_start);
		end else begin
			$display("Test %s: passed", name);
		end
		errors_at_start = errors;
	endtask

	initial begin
		arst_n          = 1'b0;
		rgmii_rx        = '0;
		cycles          = 0;
		limit           = `PHY_RESET_CYCLES + 50;
		tests_run       = 0;
		tests_failed    = 0;
		errors_at_start = 0;
		void'($urandom(60206));
		repeat (3) @(posedge tx_clk);
		#2;
		arst_n = 1'b1;

		// Frame while the PHY is still held in reset
		send_frame(8, -1, 4);
		while (!phy_rstn) begin
			@(posedge tx_clk);
		end
		repeat (20) @(posedge tx_clk);
		finish_test("phy_reset");

		repeat (30) send_frame(rand_range(1, `MAX_FRAME), -1, idle_gap);
		finish_test("good_echo");

		repeat (6) begin
			len = rand_range(1, `MAX_FRAME);
			send_frame(len, rand_range(0, len - 1), idle_gap);
		end
		finish_test("error_drop");

		repeat (4) send_frame(rand_range(`MAX_FRAME + 1, `MAX_FRAME + 20), -1, idle_gap);
		send_frame(rand_range(1, `MAX_FRAME), -1, idle_gap);
		finish_test("length_limit");

		// Second frame lands during the first one's gap
		repeat (3) begin
			send_frame(rand_range(1, `MAX_FRAME), -1, 2);
			send_frame(rand_range(1, `MAX_FRAME), -1, idle_gap);
		end
		finish_test("busy_drop");

		$display("Tests run %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (tests_failed == 0 && errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

/* board_test.f */
+incdir+hdl
hdl/gmii_pkg.sv
hdl/board_pkg.sv
hdl/rgmii_ddr_io.sv
hdl/phy_reset_gen.sv
hdl/frame_echo.sv
hdl/board_top.sv
bench/echo_checker.sv
bench/board_tb.sv
